//--- Bender.yml
package:
  name: cpu_int_ctrl

sources:
  # Design, package first
  - verilog/cpuIntPkg.sv
  - verilog/nmiIrqLatch.sv
  - verilog/boundaryCtrl.sv
  - verilog/haltCtrl.sv
  - verilog/vectorGen.sv
  - verilog/cpuIntCtrl.sv

  # Testbench with the bound checks
  - target: test
    files:
      - test/cpuIntCtrl_assert.sv
      - test/cpuIntCtrlTb.sv

//--- src.f
verilog/cpuIntPkg.sv
verilog/nmiIrqLatch.sv
verilog/boundaryCtrl.sv
verilog/haltCtrl.sv
verilog/vectorGen.sv
verilog/cpuIntCtrl.sv
test/cpuIntCtrl_assert.sv
test/cpuIntCtrlTb.sv

//--- test/cpuIntCtrlTb.sv
`timescale 1ns/10ps

module cpuIntCtrlTb;

  localparam logic [7:0] opNop = 8'hEA;
  localparam logic [7:0] opBrk = 8'h00;
  localparam logic [7:0] opCop = 8'h02;
  localparam logic [7:0] opWai = 8'hCB;
  localparam logic [7:0] opStp = 8'hDB;
  localparam int cycleLimit = 400;

  logic        CLK = 1'b0;
  logic        RST_N;
  logic        ce;
  logic        rdyIn;
  logic        nmiN;
  logic        irqN;
  logic        iFlag;
  logic        eFlag;
  logic [7:0]  dIn;
  logic        instrEnd;
  logic        vectorFetch;
  logic        vecByte;
  logic        rdyOut;
  logic [7:0]  ir;
  logic        intTaken;
  logic [23:0] aOut;
  logic        vpbN;

  int    errorCount = 0;
  int    checkCount = 0;
  int    testCount = 0;
  int    testStartErrors;
  int    cycles = 0;
  string testName;

  cpuIntCtrl cpuIntCtrl_inst
  (
    .CLK(CLK), .RST_N(RST_N), .ce(ce), .rdyIn(rdyIn),
    .nmiN(nmiN), .irqN(irqN), .iFlag(iFlag), .eFlag(eFlag), .dIn(dIn),
    .instrEnd(instrEnd), .vectorFetch(vectorFetch), .vecByte(vecByte),
    .rdyOut(rdyOut), .ir(ir), .intTaken(intTaken), .aOut(aOut), .vpbN(vpbN)
  );

  bind cpuIntCtrl cpuIntCtrlAssert cpuIntCtrlAssert_inst
  (
    .CLK(CLK), .RST_N(RST_N), .ce(ce), .rdyIn(rdyIn), .irqN(irqN),
    .nmiPending(nmiPending), .vectorFetch(vectorFetch), .vpbN(vpbN), .rdyOut(rdyOut)
  );

  always #5 CLK = ~CLK;

  // The five tests take well under half of this
  always @(posedge CLK)
  begin
    cycles++;
    if (cycles >= cycleLimit)
    begin
      $display("Run stopped after %0d cycles before the tests finished", cycleLimit);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic int failures();
    return errorCount + cpuIntCtrl_inst.cpuIntCtrlAssert_inst.assertFails;
  endfunction

  task automatic checkValue(input string what, input logic [23:0] expected,
                            input logic [23:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      $display("** Error: %s, %s: expected %h, actual %h", testName, what, expected, actual);
      errorCount++;
    end
  endtask

  task automatic startTest(input string name);
    testName = name;
    testStartErrors = failures();
  endtask

  task automatic finishTest();
    testCount++;
    if (failures() == testStartErrors)
      $display("Test %s: ok", testName);
    else
      $display("Test %s: %0d errors", testName, failures() - testStartErrors);
  endtask

  task automatic applyReset();
    RST_N = 1'b0;
    repeat (2) @(negedge CLK);
    RST_N = 1'b1;
  endtask

  // Last cycle of an instruction after a random number of execute cycles
  task automatic endInstruction();
    int gap;
    gap = $urandom_range(4, 1);
    repeat (gap) @(negedge CLK);
    instrEnd = 1'b1;
    @(negedge CLK);
    instrEnd = 1'b0;
  endtask

  // Boundary held over one cycle with rdyIn low and one with ce low
  task automatic stalledBoundary(input logic expTaken);
    @(negedge CLK);
    instrEnd = 1'b1;
    rdyIn = 1'b0;
    @(posedge CLK);
    checkValue("rdyOut with rdyIn low", 1'b0, rdyOut);
    @(negedge CLK);
    rdyIn = 1'b1;
    ce = 1'b0;
    @(posedge CLK);
    checkValue("rdyOut with ce low", 1'b0, rdyOut);
    checkValue("intTaken while stalled", expTaken, intTaken);
    @(negedge CLK);
    ce = 1'b1;
    @(negedge CLK);
    instrEnd = 1'b0;
  endtask

  // Opcode fetch, then both vector reads if the sequencer sees an interrupt or BRK/COP
  task automatic fetchAndVector(input logic [7:0] opcode, input logic expTaken,
                                input logic [23:0] expVec);
    logic doVector;
    dIn = opcode;
    @(posedge CLK);
    checkValue("intTaken at fetch", expTaken, intTaken);
    checkValue("rdyOut at fetch", 1'b1, rdyOut);
    checkValue("vpbN at fetch", 1'b1, vpbN);
    @(negedge CLK);
    dIn = opNop;
    doVector = intTaken || opcode == opBrk || opcode == opCop;
    vectorFetch = doVector;
    vecByte = 1'b0;
    @(posedge CLK);
    checkValue("ir", expTaken ? opBrk : opcode, ir);
    checkValue("rdyOut after fetch", 1'b1, rdyOut);
    if (doVector)
    begin
      checkValue("vector address, low byte", expVec, aOut);
      checkValue("vpbN at vector read", 1'b0, vpbN);
      @(negedge CLK);
      vecByte = 1'b1;
      @(posedge CLK);
      checkValue("vector address, high byte", expVec | 24'h1, aOut);
      checkValue("vpbN at vector read", 1'b0, vpbN);
    end
    @(negedge CLK);
    vectorFetch = 1'b0;
    vecByte = 1'b0;
  endtask

  task automatic expectRdyOut(input string what, input logic value, input int count);
    repeat (count)
    begin
      @(posedge CLK);
      checkValue(what, value, rdyOut);
    end
    @(negedge CLK);
  endtask

  initial
  begin
    void'($urandom(32'hb2e5cc53));
    ce = 1'b1;
    rdyIn = 1'b1;
    nmiN = 1'b1;
    irqN = 1'b1;
    iFlag = 1'b1;
    eFlag = 1'b1;
    dIn = opNop;
    instrEnd = 1'b0;
    vectorFetch = 1'b0;
    vecByte = 1'b0;
    applyReset();

    startTest("reset vector");
    fetchAndVector(opNop, 1'b1, 24'h00FFFC);
    endInstruction();
    fetchAndVector(opNop, 1'b0, 24'h0);
    finishTest();

    startTest("nmi edge");
    eFlag = 1'b0;
    nmiN = 1'b0;
    endInstruction();
    fetchAndVector(opNop, 1'b1, 24'h00FFEA);
    // NMI held low gives no second interrupt
    repeat (2)
    begin
      endInstruction();
      fetchAndVector(opNop, 1'b0, 24'h0);
    end
    nmiN = 1'b1;
    finishTest();

    startTest("irq masking");
    irqN = 1'b0;
    repeat (2)
    begin
      endInstruction();
      fetchAndVector(opNop, 1'b0, 24'h0);
    end
    iFlag = 1'b0;
    // The boundary only counts once the core is ready again
    stalledBoundary(1'b0);
    fetchAndVector(opNop, 1'b1, 24'h00FFEE);
    irqN = 1'b1;
    iFlag = 1'b1;
    endInstruction();
    fetchAndVector(opNop, 1'b0, 24'h0);
    finishTest();

    startTest("software interrupts");
    endInstruction();
    fetchAndVector(opCop, 1'b0, 24'h00FFE4);
    endInstruction();
    fetchAndVector(opBrk, 1'b0, 24'h00FFE6);
    eFlag = 1'b1;
    endInstruction();
    fetchAndVector(opBrk, 1'b0, 24'h00FFFE);
    finishTest();

    startTest("halt control");
    endInstruction();
    fetchAndVector(opWai, 1'b0, 24'h0);
    expectRdyOut("rdyOut in WAI", 1'b0, 3);
    // The raw IRQ line ends WAI even with I set
    irqN = 1'b0;
    @(negedge CLK);
    irqN = 1'b1;
    expectRdyOut("rdyOut after WAI release", 1'b1, 1);
    endInstruction();
    fetchAndVector(opStp, 1'b0, 24'h0);
    expectRdyOut("rdyOut in STP", 1'b0, 2);
    nmiN = 1'b0;
    irqN = 1'b0;
    expectRdyOut("rdyOut in STP with NMI and IRQ low", 1'b0, 4);
    nmiN = 1'b1;
    irqN = 1'b1;
    applyReset();
    fetchAndVector(opNop, 1'b1, 24'h00FFFC);
    finishTest();

    $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, failures());
    if (failures() == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- test/cpuIntCtrl_assert.sv
`timescale 1ns/10ps

module cpuIntCtrlAssert
(
  input logic CLK,
  input logic RST_N,
  input logic ce,
  input logic rdyIn,
  input logic irqN,
  input logic nmiPending,
  input logic vectorFetch,
  input logic vpbN,
  input logic rdyOut
);

  int assertFails = 0;

  // The vector-pull strobe marks exactly the vector-read cycles
  vpbFollowsFetch: assert property (@(posedge CLK) disable iff (!RST_N)
    vpbN == !vectorFetch)
  else
  begin
    $error("vpbN is not the inverse of vectorFetch");
    assertFails++;
  end

  rdyNeedsInputs: assert property (@(posedge CLK) disable iff (!RST_N)
    rdyOut |-> (rdyIn && ce))
  else
  begin
    $error("rdyOut is high while rdyIn or ce is low");
    assertFails++;
  end

  // A halted core stays halted until a ready cycle sees NMI pending or the IRQ line low
  haltHolds: assert property (@(posedge CLK) disable iff (!RST_N)
    (!rdyOut && rdyIn && ce && !nmiPending && irqN) |=> !rdyOut)
  else
  begin
    $error("rdyOut came back without NMI pending or IRQ asserted");
    assertFails++;
  end

endmodule

//--- verilog/boundaryCtrl.sv
`timescale 1ns/10ps

module boundaryCtrl
(
  input  logic                        CLK,
  input  logic                        RST_N,
  input  logic                        en,
  input  logic                        instrEnd,
  input  logic [cpuIntPkg::DATA_W-1:0] dIn,
  input  logic                        nmiPending,
  input  logic                        irqActive,
  output logic [cpuIntPkg::DATA_W-1:0] ir,
  output logic                        intTaken,
  output logic                        execCycle,
  output logic                        nmiClear,
  output logic                        resetKind,
  output cpuIntPkg::intKind_t         kind
);

  import cpuIntPkg::*;

  logic boundary;
  logic fetchCycle;
  logic execFlag;

  assign boundary  = instrEnd & en;
  assign nmiClear  = boundary & nmiPending;
  assign resetKind = (kind == KIND_RESET);
  assign execCycle = execFlag & en;

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      intTaken   <= 1'b1;
      kind       <= KIND_RESET;
      fetchCycle <= 1'b1;
      execFlag   <= 1'b0;
      ir         <= OP_BRK;
    end
    else if (en)
    begin
      fetchCycle <= instrEnd;
      execFlag   <= fetchCycle;

      // intTaken alternates so one interrupt sequence completes before the next sample
      if (instrEnd)
      begin
        intTaken <= intTaken ? 1'b0 : (nmiPending | irqActive);
        if (!intTaken && nmiPending)
          kind <= KIND_NMI;
        else if (!intTaken && irqActive)
          kind <= KIND_IRQ;
        else
          kind <= KIND_BRK;
      end

      // Opcode capture; a taken interrupt is executed as a forced BRK
      if (fetchCycle)
      begin
        ir <= intTaken ? OP_BRK : dIn;
        if (!intTaken && dIn == OP_COP)
          kind <= KIND_COP;
        else if (!intTaken && dIn == OP_BRK)
          kind <= KIND_BRK;
      end
    end
  end

endmodule

//--- verilog/cpuIntCtrl.sv
`timescale 1ns/10ps

module cpuIntCtrl
(
  input  logic                        CLK,
  input  logic                        RST_N,
  input  logic                        ce,
  input  logic                        rdyIn,
  input  logic                        nmiN,
  input  logic                        irqN,
  input  logic                        iFlag,
  input  logic                        eFlag,
  input  logic [cpuIntPkg::DATA_W-1:0] dIn,
  input  logic                        instrEnd,
  input  logic                        vectorFetch,
  input  logic                        vecByte,
  output logic                        rdyOut,
  output logic [cpuIntPkg::DATA_W-1:0] ir,
  output logic                        intTaken,
  output logic [cpuIntPkg::ADDR_W-1:0] aOut,
  output logic                        vpbN
);

  import cpuIntPkg::*;

  logic     en;
  logic     nmiPending;
  logic     irqActive;
  logic     nmiClear;
  logic     resetKind;
  logic     execCycle;
  intKind_t kind;

  assign rdyOut = en;

  nmiIrqLatch nmiIrqLatch_inst
  (
    .CLK(CLK), .RST_N(RST_N), .ce(ce), .rdyIn(rdyIn),
    .nmiN(nmiN), .irqN(irqN), .iFlag(iFlag),
    .nmiClear(nmiClear), .resetKind(resetKind),
    .nmiPending(nmiPending), .irqActive(irqActive)
  );

  boundaryCtrl boundaryCtrl_inst
  (
    .CLK(CLK), .RST_N(RST_N), .en(en), .instrEnd(instrEnd), .dIn(dIn),
    .nmiPending(nmiPending), .irqActive(irqActive),
    .ir(ir), .intTaken(intTaken), .execCycle(execCycle),
    .nmiClear(nmiClear), .resetKind(resetKind), .kind(kind)
  );

  haltCtrl haltCtrl_inst
  (
    .CLK(CLK), .RST_N(RST_N), .ce(ce), .rdyIn(rdyIn),
    .ir(ir), .intTaken(intTaken), .execCycle(execCycle),
    .nmiPending(nmiPending), .irqN(irqN), .en(en)
  );

  vectorGen vectorGen_inst
  (
    .kind(kind), .eFlag(eFlag), .vectorFetch(vectorFetch), .vecByte(vecByte),
    .aOut(aOut), .vpbN(vpbN)
  );

endmodule

//--- verilog/cpuIntPkg.sv
package cpuIntPkg;

  localparam int ADDR_W = 24;
  localparam int DATA_W = 8;

  // Kind of vector that the next vector-read cycles will fetch
  typedef enum logic [2:0]
  {
    KIND_RESET = 3'd0,
    KIND_NMI   = 3'd1,
    KIND_IRQ   = 3'd2,
    KIND_COP   = 3'd3,
    KIND_BRK   = 3'd4
  } intKind_t;

  localparam logic [DATA_W-1:0] OP_BRK = 8'h00;
  localparam logic [DATA_W-1:0] OP_COP = 8'h02;
  localparam logic [DATA_W-1:0] OP_WAI = 8'hCB;
  localparam logic [DATA_W-1:0] OP_STP = 8'hDB;

  // Address bits 23 to 4 of every vector, bank 00 and page FF
  // Bit 0 of this constant is the slot that takes the E flag
  localparam logic [19:0] VEC_HIGH = 20'h00FFE;

  // Vector slot codes, address bits 3 to 1
  localparam logic [2:0] VEC_RESET      = 3'b110;
  localparam logic [2:0] VEC_NMI        = 3'b101;
  localparam logic [2:0] VEC_IRQ        = 3'b111;
  localparam logic [2:0] VEC_COP        = 3'b010;
  // In emulation mode the top bit of the BRK slot follows E
  localparam logic [2:0] VEC_BRK_NATIVE = 3'b011;

endpackage

//--- verilog/haltCtrl.sv
`timescale 1ns/10ps

module haltCtrl
(
  input  logic                        CLK,
  input  logic                        RST_N,
  input  logic                        ce,
  input  logic                        rdyIn,
  input  logic [cpuIntPkg::DATA_W-1:0] ir,
  input  logic                        intTaken,
  input  logic                        execCycle,
  input  logic                        nmiPending,
  input  logic                        irqN,
  output logic                        en
);

  import cpuIntPkg::*;

  logic waiting;
  logic stopped;
  logic wake;

  // WAI wakes on the raw IRQ line, so a masked IRQ still releases it
  assign wake = rdyIn & ce & (nmiPending | ~irqN);

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      waiting <= 1'b0;
      stopped <= 1'b0;
    end
    else
    begin
      if (execCycle && !intTaken)
      begin
        if (ir == OP_WAI)
          waiting <= 1'b1;
        else if (ir == OP_STP)
          stopped <= 1'b1;
      end
      if (waiting && wake)
        waiting <= 1'b0;
    end
  end

  assign en = rdyIn & ce & ~waiting & ~stopped;

endmodule

//--- verilog/nmiIrqLatch.sv
`timescale 1ns/10ps

module nmiIrqLatch
(
  input  logic CLK,
  input  logic RST_N,
  input  logic ce,
  input  logic rdyIn,
  input  logic nmiN,
  input  logic irqN,
  input  logic iFlag,
  input  logic nmiClear,
  input  logic resetKind,
  output logic nmiPending,
  output logic irqActive
);

  logic nmiPrev;
  logic sampleEn;
  logic nmiFall;

  // NMI is sampled on every ready cycle, but not while the reset vector is pending
  assign sampleEn = rdyIn & ce & ~resetKind;

  // A held-low line gives one edge only, since nmiPrev follows the line
  assign nmiFall = ~nmiN & nmiPrev;

  always_ff @(posedge CLK or negedge RST_N)
  begin
    if (!RST_N)
    begin
      nmiPrev    <= 1'b1;
      nmiPending <= 1'b0;
    end
    else if (sampleEn)
    begin
      nmiPrev <= nmiN;
      if (nmiFall && !nmiPending)
      begin
        nmiPending <= 1'b1;
      end
      else if (nmiClear)
      begin
        nmiPending <= 1'b0;
      end
    end
  end

  // IRQ is level sensitive and masked by the I flag
  assign irqActive = ~irqN & ~iFlag;

endmodule

//--- verilog/vectorGen.sv
`timescale 1ns/10ps

module vectorGen
(
  input  cpuIntPkg::intKind_t         kind,
  input  logic                        eFlag,
  input  logic                        vectorFetch,
  input  logic                        vecByte,
  output logic [cpuIntPkg::ADDR_W-1:0] aOut,
  output logic                        vpbN
);

  import cpuIntPkg::*;

  logic [2:0]        slot;
  logic [ADDR_W-1:0] vecAddr;

  always_comb
  begin
    case (kind)
      KIND_RESET:
        slot = VEC_RESET;
      KIND_NMI:
        slot = VEC_NMI;
      KIND_IRQ:
        slot = VEC_IRQ;
      KIND_COP:
        slot = VEC_COP;
      default:
        // BRK moves from FFE6 to FFFE in emulation mode
        slot = VEC_BRK_NATIVE | {eFlag, 2'b00};
    endcase
  end

  // E selects the emulation-mode vector page half at bit 4
  assign vecAddr = {VEC_HIGH[19:1], eFlag, slot, vecByte};

  // Outside the vector cycles the address bus belongs to the sequencer
  assign aOut = vectorFetch ? vecAddr : '0;

  assign vpbN = ~vectorFetch;

endmodule
